// File: logic/core_params.svh
// core-wide sizing and reset constants, `include this wherever a width or reset value is needed
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data path and address width, RV64
`define CORE_XLEN 64

// architectural integer registers x0..x31
`define CORE_REG_COUNT 32

// first fetch address after reset
`define CORE_RESET_PC 64'h0000_0000_0000_0000

// addi x0, x0, 0
// loaded into the instruction register on reset and whenever the fetched word is flushed
`define CORE_NOP 32'h0000_0013

`endif

// File: logic/rv_isa_pkg.sv
// RV64I encodings for the kept instruction subset, referenced by the decoder as rv_isa_pkg::name
package rv_isa_pkg;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111
    } opcode_e;

    typedef logic [2:0] funct3_t; // inst[14:12]

    // loads and stores
    localparam funct3_t f3_lb = 3'b000;
    localparam funct3_t f3_ld = 3'b011;
    localparam funct3_t f3_sd = 3'b011;

    // branches
    localparam funct3_t f3_beq = 3'b000;
    localparam funct3_t f3_bne = 3'b001;
    localparam funct3_t f3_blt = 3'b100;

    // alu group, shared by op and op_imm
    localparam funct3_t f3_add_sub = 3'b000;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;

    // bit position inside funct7 (inst[31:25]) that turns add into sub
    localparam int unsigned funct7_sub = 5;

endpackage

// File: logic/core_types_pkg.sv
// datapath types shared by the core modules, referenced as core_types_pkg::name
`include "core_params.svh"

package core_types_pkg;

    typedef logic [`CORE_XLEN-1:0] xlen_t;                    // data word and byte address
    typedef logic [31:0] inst_t;                              // one instruction word
    typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_addr_t;   // x0..x31 index

    // operations the alu can perform
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_slt,  // signed set-less-than
        alu_xor,
        alu_or,
        alu_and
    } alu_op_e;

    // which immediate format imm_gen hands back
    typedef enum logic [2:0] {
        imm_i,  // op_imm, loads
        imm_s,  // stores
        imm_b,  // branches, low bit zero
        imm_u,  // lui, auipc
        imm_j   // jal, low bit zero
    } imm_sel_e;

endpackage

// File: logic/alu.sv
// 64-bit integer alu for the execute stage, also supplies the branch compare flags
`timescale 1ns/1ps

module alu (
    input  core_types_pkg::alu_op_e alu_op,
    input  core_types_pkg::xlen_t   a,
    input  core_types_pkg::xlen_t   b,
    output core_types_pkg::xlen_t   result,
    output logic                    eq,     // a == b, beq/bne
    output logic                    lt      // signed a < b, blt and slt
);

    core_types_pkg::xlen_t sum;
    core_types_pkg::xlen_t diff;

    assign sum  = a + b;
    assign diff = a - b;

    assign eq = (a == b);
    assign lt = ($signed(a) < $signed(b));

    always_comb begin
        case (alu_op)
            core_types_pkg::alu_add: result = sum;
            core_types_pkg::alu_sub: result = diff;
            core_types_pkg::alu_slt: result = core_types_pkg::xlen_t'(lt); // 0 or 1
            core_types_pkg::alu_xor: result = a ^ b;
            core_types_pkg::alu_or:  result = a | b;
            core_types_pkg::alu_and: result = a & b;
            default:                 result = '0;
        endcase
    end

endmodule

// File: logic/imm_gen.sv
// immediate generator: forms the sign-extended I/S/B/U/J values and returns the one decode asks for
`timescale 1ns/1ps
`include "core_params.svh"

module imm_gen (
    input  core_types_pkg::inst_t    inst,
    input  core_types_pkg::imm_sel_e imm_sel,
    output core_types_pkg::xlen_t    imm
);

    core_types_pkg::xlen_t imm_i_val;
    core_types_pkg::xlen_t imm_s_val;
    core_types_pkg::xlen_t imm_b_val;
    core_types_pkg::xlen_t imm_u_val;
    core_types_pkg::xlen_t imm_j_val;

    // inst[31] is the sign bit in every format
    assign imm_i_val = {{(`CORE_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s_val = {{(`CORE_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b_val = {{(`CORE_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                        inst[11:8], 1'b0};                          // 13-bit, even
    assign imm_u_val = {{(`CORE_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j_val = {{(`CORE_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                        inst[30:21], 1'b0};                         // 21-bit, even

    always_comb begin
        case (imm_sel)
            core_types_pkg::imm_s: imm = imm_s_val;
            core_types_pkg::imm_b: imm = imm_b_val;
            core_types_pkg::imm_u: imm = imm_u_val;
            core_types_pkg::imm_j: imm = imm_j_val;
            default:               imm = imm_i_val;
        endcase
    end

endmodule

// File: logic/reg_file.sv
// integer register file, two combinational reads and one write per clock, x0 held at zero
`timescale 1ns/1ps
`include "core_params.svh"

module reg_file (
    input  logic                      clk_1hz,
    input  logic                      reset_n,
    input  core_types_pkg::reg_addr_t rs1,
    input  core_types_pkg::reg_addr_t rs2,
    output core_types_pkg::xlen_t     rs1_data,
    output core_types_pkg::xlen_t     rs2_data,
    input  core_types_pkg::reg_addr_t rd,
    input  logic                      we,
    input  core_types_pkg::xlen_t     wdata
);

    core_types_pkg::xlen_t regs [`CORE_REG_COUNT];

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin // x0 writes dropped
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    a_x0_zero: assert property (@(posedge clk_1hz) disable iff (!reset_n)
        (rs1 == '0) |-> (rs1_data == '0))
        else $error("x0 read back non-zero");

endmodule

// File: logic/fetch_stage.sv
// fetch stage of the two-stage core with program counter, instruction register and redirect flush
`timescale 1ns/1ps
`include "core_params.svh"

module fetch_stage (
    input  logic                  clk_1hz,
    input  logic                  reset_n,
    input  logic                  redirect,     // taken branch or jal in execute
    input  core_types_pkg::xlen_t redirect_pc,
    input  core_types_pkg::inst_t imem_rdata,   // combinational read of imem_addr
    output core_types_pkg::xlen_t imem_addr,
    output core_types_pkg::xlen_t pc_ex,        // pc of the word now in inst
    output core_types_pkg::inst_t inst          // instruction register
);

    core_types_pkg::xlen_t pc; // address being fetched this cycle

    assign imem_addr = pc;

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            pc    <= `CORE_RESET_PC;
            pc_ex <= `CORE_RESET_PC;
            inst  <= `CORE_NOP;
        end else if (redirect) begin
            pc    <= redirect_pc; // restart fetch at the target
            pc_ex <= pc;          // unused since the slot holds a nop
            inst  <= `CORE_NOP;   // drop the word fetched behind the jump
        end else begin
            pc    <= pc + core_types_pkg::xlen_t'(4);
            pc_ex <= pc;
            inst  <= imem_rdata;
        end
    end

    // flushed slot holds a nop and must not redirect again
    a_flush_nop: assert property (@(posedge clk_1hz) disable iff (!reset_n)
        redirect |=> (inst == `CORE_NOP && !redirect))
        else $error("instruction after redirect was not flushed");

endmodule

// File: logic/exec_control.sv
// execute-stage decoder that steers alu operands, writeback, data memory and pc redirect each cycle
`timescale 1ns/1ps
`include "core_params.svh"

module exec_control (
    input  core_types_pkg::inst_t     inst,
    input  core_types_pkg::xlen_t     pc_ex,
    input  core_types_pkg::xlen_t     rs1_data,
    input  core_types_pkg::xlen_t     rs2_data,
    input  core_types_pkg::xlen_t     imm,
    input  core_types_pkg::xlen_t     alu_result,
    input  logic                      alu_eq,
    input  logic                      alu_lt,
    input  core_types_pkg::xlen_t     dmem_rdata,
    output core_types_pkg::reg_addr_t rs1,
    output core_types_pkg::reg_addr_t rs2,
    output core_types_pkg::reg_addr_t rd,
    output logic                      rf_we,
    output core_types_pkg::xlen_t     rf_wdata,
    output core_types_pkg::alu_op_e   alu_op,
    output core_types_pkg::xlen_t     alu_a,
    output core_types_pkg::xlen_t     alu_b,
    output core_types_pkg::imm_sel_e  imm_sel,
    output core_types_pkg::xlen_t     dmem_addr,
    output core_types_pkg::xlen_t     dmem_wdata,
    output logic                      dmem_we,
    output logic                      redirect,
    output core_types_pkg::xlen_t     redirect_pc
);

    rv_isa_pkg::opcode_e   opcode;
    rv_isa_pkg::funct3_t   funct3;
    core_types_pkg::alu_op_e arith_op;  // alu op named by funct3/funct7
    logic                  arith_ok;   // funct3 is one we implement
    core_types_pkg::xlen_t load_shift;
    logic [7:0]            load_byte;

    assign opcode = rv_isa_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign dmem_addr   = alu_result;      // rs1 + imm for loads and stores
    assign dmem_wdata  = rs2_data;
    assign redirect_pc = pc_ex + imm;     // branch and jal target from its own adder

    // lb picks a byte by the low address bits within the doubleword
    assign load_shift = dmem_rdata >> {alu_result[2:0], 3'b000};
    assign load_byte  = load_shift[7:0];

    // shared funct3 decode for op and op_imm
    // sub only exists in the register form
    always_comb begin
        arith_ok = 1'b1;
        case (funct3)
            rv_isa_pkg::f3_add_sub:
                arith_op = (opcode == rv_isa_pkg::opc_op && inst[25 + rv_isa_pkg::funct7_sub])
                         ? core_types_pkg::alu_sub : core_types_pkg::alu_add;
            rv_isa_pkg::f3_slt: arith_op = core_types_pkg::alu_slt;
            rv_isa_pkg::f3_xor: arith_op = core_types_pkg::alu_xor;
            rv_isa_pkg::f3_or:  arith_op = core_types_pkg::alu_or;
            rv_isa_pkg::f3_and: arith_op = core_types_pkg::alu_and;
            default: begin
                arith_op = core_types_pkg::alu_add;
                arith_ok = 1'b0;              // shifts and sltu act as a nop
            end
        endcase
    end

    always_comb begin
        rf_we    = 1'b0;
        rf_wdata = alu_result;
        alu_op   = core_types_pkg::alu_add;
        alu_a    = rs1_data;
        alu_b    = rs2_data;
        imm_sel  = core_types_pkg::imm_i;
        dmem_we  = 1'b0;
        redirect = 1'b0;
        case (opcode)
            rv_isa_pkg::opc_lui: begin
                imm_sel  = core_types_pkg::imm_u;
                rf_we    = 1'b1;
                rf_wdata = imm;               // already sign-extended
            end
            rv_isa_pkg::opc_auipc: begin
                imm_sel = core_types_pkg::imm_u;
                alu_a   = pc_ex;
                alu_b   = imm;
                rf_we   = 1'b1;
            end
            rv_isa_pkg::opc_op_imm: begin
                alu_b  = imm;
                alu_op = arith_op;
                rf_we  = arith_ok;
            end
            rv_isa_pkg::opc_op: begin
                alu_op = arith_op;
                rf_we  = arith_ok;
            end
            rv_isa_pkg::opc_load: begin
                alu_b = imm;
                if (funct3 == rv_isa_pkg::f3_lb) begin
                    rf_we    = 1'b1;
                    rf_wdata = {{(`CORE_XLEN-8){load_byte[7]}}, load_byte};
                end else if (funct3 == rv_isa_pkg::f3_ld) begin
                    rf_we    = 1'b1;
                    rf_wdata = dmem_rdata;
                end
            end
            rv_isa_pkg::opc_store: begin
                imm_sel = core_types_pkg::imm_s;
                alu_b   = imm;
                dmem_we = (funct3 == rv_isa_pkg::f3_sd); // only sd is kept
            end
            rv_isa_pkg::opc_branch: begin
                imm_sel = core_types_pkg::imm_b;  // alu only compares rs1 with rs2 here
                case (funct3)
                    rv_isa_pkg::f3_beq: redirect = alu_eq;
                    rv_isa_pkg::f3_bne: redirect = !alu_eq;
                    rv_isa_pkg::f3_blt: redirect = alu_lt;
                    default:            redirect = 1'b0;
                endcase
            end
            rv_isa_pkg::opc_jal: begin
                imm_sel  = core_types_pkg::imm_j;
                rf_we    = 1'b1;
                rf_wdata = pc_ex + core_types_pkg::xlen_t'(4); // link
                redirect = 1'b1;
            end
            default: ;                        // unknown opcodes do nothing
        endcase
    end

    // a store never also writes a register
    always_comb begin
        a_we_exclusive: assert (!(dmem_we && rf_we))
            else $error("dmem_we and rf_we asserted together");
    end

endmodule

// File: logic/rv_core.sv
// top of the two-stage RV64 core, connects fetch, decode and datapath and exposes both memory ports
`timescale 1ns/1ps

module rv_core (
    input  logic                  clk_1hz,
    input  logic                  reset_n,
    output core_types_pkg::xlen_t imem_addr,
    input  core_types_pkg::inst_t imem_rdata,
    output core_types_pkg::xlen_t dmem_addr,
    output core_types_pkg::xlen_t dmem_wdata,
    output logic                  dmem_we,
    input  core_types_pkg::xlen_t dmem_rdata
);

    core_types_pkg::inst_t     inst;
    core_types_pkg::xlen_t     pc_ex;
    core_types_pkg::xlen_t     redirect_pc;
    logic                      redirect;
    core_types_pkg::reg_addr_t rs1, rs2, rd;
    core_types_pkg::xlen_t     rs1_data, rs2_data;
    logic                      rf_we;
    core_types_pkg::xlen_t     rf_wdata;
    core_types_pkg::alu_op_e   alu_op;
    core_types_pkg::xlen_t     alu_a, alu_b, alu_result;
    logic                      alu_eq, alu_lt;
    core_types_pkg::imm_sel_e  imm_sel;
    core_types_pkg::xlen_t     imm;

    fetch_stage u_fetch_stage (
        .clk_1hz, .reset_n, .redirect, .redirect_pc, .imem_rdata,
        .imem_addr, .pc_ex, .inst
    );

    exec_control u_exec_control (
        .inst, .pc_ex, .rs1_data, .rs2_data, .imm, .alu_result, .alu_eq, .alu_lt,
        .dmem_rdata, .rs1, .rs2, .rd, .rf_we, .rf_wdata, .alu_op, .alu_a, .alu_b,
        .imm_sel, .dmem_addr, .dmem_wdata, .dmem_we, .redirect, .redirect_pc
    );

    reg_file u_reg_file (
        .clk_1hz, .reset_n, .rs1, .rs2, .rs1_data, .rs2_data,
        .rd, .we(rf_we), .wdata(rf_wdata)
    );

    imm_gen u_imm_gen (.inst, .imm_sel, .imm);

    alu u_alu (
        .alu_op, .a(alu_a), .b(alu_b), .result(alu_result), .eq(alu_eq), .lt(alu_lt)
    );

endmodule

// File: dv/tb_rv_core.sv
// testbench for rv_core that runs the program from the testdata file and checks each store it makes
`timescale 1ns/1ps
`include "core_params.svh"

module tb_rv_core;

    // layout of the testdata image in 64-bit words
    localparam int TDATA_WORDS  = 128;
    localparam int PROG_WORDS   = 64;
    localparam int DATA_BASE    = 64;   // initial data memory of 16 doublewords
    localparam int DATA_WORDS   = 16;
    localparam int COUNT_WORD   = 80;   // number of expected stores
    localparam int EXP_BASE     = 81;   // address/data pairs from here on
    localparam int MAX_STORES   = (TDATA_WORDS - EXP_BASE) / 2;
    localparam int WAIT_CYCLES  = 2000;
    localparam int QUIET_CYCLES = 50;   // window for stray stores after the last one

    logic                  clk_1hz;
    logic                  reset_n;
    core_types_pkg::xlen_t imem_addr;
    core_types_pkg::inst_t imem_rdata;
    core_types_pkg::xlen_t dmem_addr;
    core_types_pkg::xlen_t dmem_wdata;
    logic                  dmem_we;
    core_types_pkg::xlen_t dmem_rdata;

    core_types_pkg::xlen_t tdata [0:TDATA_WORDS-1]; // raw file image
    core_types_pkg::inst_t imem  [0:PROG_WORDS-1];
    core_types_pkg::xlen_t dmem  [0:DATA_WORDS-1];

    int                    store_count = 0;
    int                    stores_seen = 0;
    logic                  wr_pending  = 1'b0;     // store seen this cycle lands after the edge
    logic [3:0]            wr_idx      = '0;
    core_types_pkg::xlen_t wr_data     = '0;

    rv_core u_rv_core (
        .clk_1hz, .reset_n, .imem_addr, .imem_rdata,
        .dmem_addr, .dmem_wdata, .dmem_we, .dmem_rdata
    );

    // both memories answer in the same cycle
    assign imem_rdata = imem[imem_addr[7:2]];     // word addressed
    assign dmem_rdata = dmem[dmem_addr[6:3]];     // doubleword addressed and wraps at 128 bytes

    initial begin
        clk_1hz = 1'b0;
        forever #4 clk_1hz = ~clk_1hz;            // 8 ns period
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_addr(input core_types_pkg::xlen_t got,
                              input core_types_pkg::xlen_t exp, input int n);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0d ns: store %0d address %h, expected %h",
                                $time, n, got, exp));
        end
    endtask

    task automatic check_data(input core_types_pkg::xlen_t got,
                              input core_types_pkg::xlen_t exp, input int n);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0d ns: store %0d data %h, expected %h",
                                $time, n, got, exp));
        end
    endtask

    // store outputs sampled mid-cycle
    always @(negedge clk_1hz) begin
        if (reset_n && dmem_we) begin
            if (stores_seen >= store_count) begin
                abort_run($sformatf("unexpected extra store to address %h at %0d ns",
                                    dmem_addr, $time));
            end else begin
                check_addr(dmem_addr, tdata[EXP_BASE + 2 * stores_seen], stores_seen);
                check_data(dmem_wdata, tdata[EXP_BASE + 2 * stores_seen + 1], stores_seen);
                wr_pending  = 1'b1;
                wr_idx      = dmem_addr[6:3];
                wr_data     = dmem_wdata;
                stores_seen = stores_seen + 1;
            end
        end
    end

    // memory model update 1 ns after the edge the store retires on
    always @(posedge clk_1hz) begin
        if (wr_pending) begin
            #1;
            dmem[wr_idx] = wr_data;
            wr_pending   = 1'b0;
        end
    end

    initial begin
        int cycles;
        reset_n = 1'b0;
        void'($urandom(54287));
        for (int i = 0; i < TDATA_WORDS; i++) begin
            tdata[i] = '0;
        end
        for (int i = 0; i < PROG_WORDS; i++) begin
            tdata[i] = {32'h0, `CORE_NOP};                  // unused program slots
        end
        for (int i = DATA_BASE; i < DATA_BASE + DATA_WORDS; i++) begin
            tdata[i] = {$urandom, $urandom};                // never loaded by the program
        end
        $readmemh("dv/rv_core_testdata.mem", tdata);
        for (int i = 0; i < PROG_WORDS; i++) begin
            imem[i] = tdata[i][31:0];
        end
        for (int i = 0; i < DATA_WORDS; i++) begin
            dmem[i] = tdata[DATA_BASE + i];
        end
        store_count = int'(tdata[COUNT_WORD][31:0]);
        if (store_count < 1 || store_count > MAX_STORES) begin
            abort_run("store count in the testdata file is out of range");
        end

        for (int i = 0; i < 16; i++) begin
            @(posedge clk_1hz);
        end
        #1 reset_n = 1'b1;

        cycles = 0;
        while (stores_seen < store_count && cycles < WAIT_CYCLES) begin
            @(posedge clk_1hz);
            cycles = cycles + 1;
        end
        if (stores_seen < store_count) begin
            abort_run($sformatf("timeout: only %0d of %0d stores arrived in %0d cycles",
                                stores_seen, store_count, WAIT_CYCLES));
        end

        cycles = 0;
        while (cycles < QUIET_CYCLES) begin   // monitor flags any stray store here
            @(posedge clk_1hz);
            cycles = cycles + 1;
        end

        if (stores_seen == store_count) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run("store count changed after the program finished");
        end
    end

endmodule

// File: filelist.f
+incdir+logic
logic/rv_isa_pkg.sv
logic/core_types_pkg.sv
logic/alu.sv
logic/imm_gen.sv
logic/reg_file.sv
logic/fetch_stage.sv
logic/exec_control.sv
logic/rv_core.sv
dv/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# build the rv_core testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_rv_core \
    -f filelist.f --Mdir obj_dir -o tb_rv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_rv_core > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
exit 0

// File: dv/rv_core_testdata.mem
// words 0..63 program (one instruction per word), @40 initial data memory doublewords,
// @50 expected store count, then one "address data" pair per store in program order
00003883 00900903 800000B7 12345117 // ld x17,0  lb x18,9  lui x1  auipc x2 at 0x0c
FFB00193 00C00213 06418293 FFD1A313 // x3=-5  x4=12  addi x5,x3,100  slti x6,x3,-3
FFF24393 50126413 7F01F493 00418533 // xori x7  ori x8  andi x9  add x10
404185B3 0041A633 003226B3 0041C733 // sub x11  slt x12  slt x13 (reversed)  xor x14
0041E7B3 0041F833 07B00013 00418033 // or x15  and x16  addi x0  add x0
10103023 10203423 10503823 10603C23 // sd x1 x2 x5 x6 to 0x100..0x118
12703023 12803423 12903823 12A03C23 // sd x7 x8 x9 x10
14B03023 14C03423 14D03823 14E03C23 // sd x11 x12 x13 x14
16F03023 17003423 17103823 17203C23 // sd x15 x16 x17 x18
18003023 00318463 001A0A13 00418463 // sd x0  beq taken +8  marker 1  beq not taken
002A0A13 00419463 004A0A13 00421463 // marker 2  bne taken  marker 4  bne not taken
008A0A13 0041C463 010A0A13 00324463 // marker 8  blt taken  marker 16  blt not taken
020A0A13 19403423 00800AEF 00100B13 // marker 32  sd x20  jal x21,+8  skipped addi x22
19503823 19603C23 0000006F          // sd x21  sd x22  jal x0,0 parks the core
@40
1122334455667788 0123456789AB9C5A   // ld source at 0x00, byte 0x9c at 0x09 for lb
@50
14                                  // 20 stores
100 FFFFFFFF80000000  108 000000001234500C
110 000000000000005F  118 0000000000000001
120 FFFFFFFFFFFFFFF3  128 000000000000050D
130 00000000000007F0  138 0000000000000007
140 FFFFFFFFFFFFFFEF  148 0000000000000001
150 0000000000000000  158 FFFFFFFFFFFFFFF7
160 FFFFFFFFFFFFFFFF  168 0000000000000008
170 1122334455667788  178 FFFFFFFFFFFFFF9C
180 0000000000000000  188 000000000000002A
190 00000000000000CC  198 0000000000000000
